// ==== sim.f ====
+incdir+include
rtl/rv_pkg.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/core_ctrl.sv
rtl/rv_core.sv
testbench/tb_rv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_rv_core
RTL_TOP ?= rv_core
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== include/tb_ref_model.svh ====
// ISA model for the tb only; needs prog, ref_mem, exp_out and mem_words from the including module
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// returns the instruction count up to and including the halt, or -1 if the image never halts
function automatic int run_ref();
    logic [31:0] x [32];
    logic [31:0] pc;
    logic [31:0] nxt;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [31:0] imm;
    logic [31:0] ea;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic        wb;
    for (int i = 0; i < mem_words; i++) begin
        ref_mem[i] = prog[i];
    end
    for (int i = 0; i < 32; i++) begin
        x[i] = '0;
    end
    exp_out.delete();
    pc = '0;
    for (int steps = 0; steps < 100000; steps++) begin
        w = ref_mem[pc[11:2]];
        f7 = w[31:25];
        f3 = w[14:12];
        a = x[w[19:15]];
        b = x[w[24:20]];
        wb = 1'b0;
        r = '0;
        nxt = pc + 4;
        case (w[6:0])
            7'b0010011: begin
                imm = {{20{w[31]}}, w[31:20]};
                wb = 1'b1;
                case (f3)
                    3'd0: r = a + imm;
                    3'd1: r = a << w[24:20];
                    3'd2: r = {31'b0, $signed(a) < $signed(imm)};
                    3'd3: r = {31'b0, a < imm};
                    3'd4: r = a ^ imm;
                    3'd5: begin
                        if (f7[5]) begin
                            r = $signed(a) >>> w[24:20];
                        end else begin
                            r = a >> w[24:20];
                        end
                    end
                    3'd6: r = a | imm;
                    default: r = a & imm;
                endcase
            end
            7'b0110011: begin
                wb = 1'b1;
                case ({f7, f3})
                    10'h000: r = a + b;
                    10'h100: r = a - b;
                    10'h001: r = a << b[4:0];
                    10'h002: r = {31'b0, $signed(a) < $signed(b)};
                    10'h003: r = {31'b0, a < b};
                    10'h004: r = a ^ b;
                    10'h005: r = a >> b[4:0];
                    10'h105: r = $signed(a) >>> b[4:0];
                    10'h006: r = a | b;
                    10'h007: r = a & b;
                    default: return steps + 1;
                endcase
            end
            7'b0110111: begin
                r = {w[31:12], 12'b0};
                wb = 1'b1;
            end
            7'b0010111: begin
                r = pc + {w[31:12], 12'b0};
                wb = 1'b1;
            end
            7'b1100011: begin
                imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                case (f3)
                    3'd0: wb = (a == b);
                    3'd1: wb = (a != b);
                    3'd4: wb = ($signed(a) < $signed(b));
                    3'd5: wb = ($signed(a) >= $signed(b));
                    3'd6: wb = (a < b);
                    3'd7: wb = (a >= b);
                    default: return steps + 1;
                endcase
                if (wb) begin
                    nxt = pc + imm;
                end
                wb = 1'b0;
            end
            7'b0000011: begin
                ea = a + {{20{w[31]}}, w[31:20]};
                r = ref_mem[ea[11:2]];
                wb = 1'b1;
            end
            7'b0100011: begin
                ea = a + {{20{w[31]}}, w[31:25], w[11:7]};
                if (ea == 32'd1000) begin
                    exp_out.push_back(b);
                end else if (ea == 32'd1004) begin
                    return steps + 1;
                end else begin
                    ref_mem[ea[11:2]] = b;
                end
            end
            default: return steps + 1;
        endcase
        if (wb && (w[11:7] != 5'd0)) begin
            x[w[11:7]] = r;
        end
        pc = nxt;
    end
    return -1;
endfunction

`endif

// ==== testbench/tb_rv_core.sv ====
// 4 KB word memory model at byte 0, random 1..4 cycle acknowledge; programs end in a halt store
module tb_rv_core;
    import rv_pkg::*;

    localparam int mem_words = 1024;
    localparam int halt_timeout = 20000;

    logic     clk;
    logic     rst;
    mem_req_t mem_req;
    data_t    mem_rd_data;
    logic     mem_ack;
    data_t    out_data;
    logic     out_valid;
    logic     halt;

    data_t prog [mem_words];
    data_t mem [mem_words];
    data_t ref_mem [mem_words];
    data_t exp_out [$];
    int    out_idx;
    int    errors;
    int    tests_run;
    int    tests_failed;
    int    wp;

    // pending request of the memory model
    logic  pending;
    logic  pend_wr;
    addr_t pend_addr;
    data_t pend_data;
    int    pend_delay;
    logic  ack_next;
    data_t rd_next;

    `include "tb_ref_model.svh"

    rv_core dut0 (
        .clk         (clk),
        .rst         (rst),
        .mem_req     (mem_req),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .halt        (halt)
    );

    always #20 clk = ~clk;

    // capture requests and count down to the acknowledge
    always @(posedge clk) begin
        ack_next = 1'b0;
        rd_next = '0;
        if (rst) begin
            pending = 1'b0;
        end else begin
            if (mem_req.rd_req || mem_req.wr_req) begin
                // a second request before the acknowledge is an overlap
                if (pending) begin
                    $display("request issued while an earlier one was still unacknowledged");
                    errors++;
                end
                pending = 1'b1;
                pend_wr = mem_req.wr_req;
                pend_addr = mem_req.addr;
                pend_data = mem_req.wr_data;
                pend_delay = 1 + ($urandom % 4);
            end
            if (pending) begin
                pend_delay--;
                if (pend_delay == 0) begin
                    ack_next = 1'b1;
                    if (pend_wr) begin
                        mem[pend_addr[11:2]] = pend_data;
                    end else begin
                        rd_next = mem[pend_addr[11:2]];
                    end
                    pending = 1'b0;
                end
            end
        end
    end

    // acknowledge on the falling edge
    always @(negedge clk) begin
        mem_ack = ack_next;
        mem_rd_data = rd_next;
    end

    // output compare
    always @(posedge clk) begin
        if (!rst && out_valid) begin
            if (out_idx >= exp_out.size()) begin
                $display("unexpected extra output %h", out_data);
                errors++;
            end else if (out_data != exp_out[out_idx]) begin
                $display("[ERROR] out_data got %h expected %h", out_data, exp_out[out_idx]);
                errors++;
            end
            out_idx++;
        end
    end

    function automatic instr_t enc_r(logic [9:0] fn, int rd, int rs1, int rs2);
        return {fn[9:3], rs2[4:0], rs1[4:0], fn[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic instr_t enc_i(logic [6:0] op, logic [2:0] f3, int rd, int rs1,
                                     logic [11:0] imm);
        return {imm, rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic instr_t enc_s(int rs1, int rs2, logic [11:0] imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic instr_t enc_b(logic [2:0] f3, int rs1, int rs2, logic [12:0] imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic instr_t enc_u(logic [6:0] op, int rd, logic [19:0] imm);
        return {imm, rd[4:0], op};
    endfunction

    task automatic emit(instr_t w);
        prog[wp] = w;
        wp++;
    endtask

    task automatic clear_prog();
        for (int i = 0; i < mem_words; i++) begin
            prog[i] = (i * 32'h9e37_79b9) ^ 32'h0bad_0000;
        end
        wp = 0;
    endtask

    // lui rounds up so that the signed addi lands on the value
    task automatic load_imm(int rd, data_t v);
        data_t hi;
        hi = v + 32'h800;
        emit(enc_u(7'b0110111, rd, hi[31:12]));
        emit(enc_i(7'b0010011, 3'b000, rd, rd, v[11:0]));
    endtask

    task automatic put_out(int rs);
        emit(enc_s(0, rs, 12'd1000));
    endtask

    task automatic put_halt();
        emit(enc_s(0, 0, 12'd1004));
    endtask

    task automatic addi(int rd, int rs1, logic [11:0] imm);
        emit(enc_i(7'b0010011, 3'b000, rd, rs1, imm));
    endtask

    task automatic reset_dut();
        @(negedge clk);
        rst = 1'b1;
        out_idx = 0;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = prog[i];
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic run_test(string name);
        int errs0;
        int exp_steps;
        int cycles;
        errs0 = errors;
        exp_steps = run_ref();
        if (exp_steps < 0) begin
            $display("reference model never reached a halt");
            errors++;
        end
        reset_dut();
        cycles = 0;
        while (!halt && cycles < halt_timeout) begin
            @(posedge clk);
            cycles++;
        end
        if (!halt) begin
            $display("stalled core, no halt within %0d cycles", halt_timeout);
            errors++;
        end else begin
            for (int i = 0; i < 50; i++) begin
                @(posedge clk);
                if (mem_req.rd_req || mem_req.wr_req || out_valid || !halt) begin
                    $display("core activity or halt drop after halt");
                    errors++;
                end
            end
            if (out_idx != exp_out.size()) begin
                $display("got %0d outputs but expected %0d", out_idx, exp_out.size());
                errors++;
            end
            for (int i = 0; i < mem_words; i++) begin
                if (mem[i] != ref_mem[i]) begin
                    $display("[ERROR] mem[%0d] got %h expected %h", i, mem[i], ref_mem[i]);
                    errors++;
                end
            end
        end
        tests_run++;
        if (errors == errs0) begin
            $display("%s: ok, %0d instructions", name, exp_steps);
        end else begin
            tests_failed++;
            $display("%s: failed, %0d errors", name, errors - errs0);
        end
    endtask

    initial begin
        logic [9:0] op_fn [10];
        logic [2:0] br_fn [6];
        int loop_at;
        op_fn = '{10'h000, 10'h100, 10'h001, 10'h002, 10'h003,
                  10'h004, 10'h005, 10'h105, 10'h006, 10'h007};
        br_fn = '{3'd4, 3'd6, 3'd5, 3'd7, 3'd0, 3'd1};
        clk = 1'b0;
        rst = 1'b1;
        mem_ack = 1'b0;
        mem_rd_data = '0;
        pending = 1'b0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        out_idx = 0;
        void'($urandom(32'hde15_e966));

        // register-register ops with a negative rs1 in the first pair
        clear_prog();
        for (int k = 0; k < 3; k++) begin
            load_imm(1, (k == 0) ? ($urandom | 32'h8000_0000) : $urandom);
            load_imm(2, $urandom);
            for (int j = 0; j < 10; j++) begin
                emit(enc_r(op_fn[j], 3, 1, 2));
                put_out(3);
            end
        end
        put_halt();
        run_test("register ALU");

        // immediate ops on a negative value
        clear_prog();
        load_imm(1, $urandom | 32'h8000_0000);
        emit(enc_i(7'b0010011, 3'd0, 3, 1, -12'sd123));
        put_out(3);
        emit(enc_i(7'b0010011, 3'd2, 3, 1, -12'sd1));
        put_out(3);
        emit(enc_i(7'b0010011, 3'd3, 3, 1, -12'sd1));
        put_out(3);
        emit(enc_i(7'b0010011, 3'd4, 3, 1, -12'sd256));
        put_out(3);
        emit(enc_i(7'b0010011, 3'd6, 3, 1, -12'sd2048));
        put_out(3);
        emit(enc_i(7'b0010011, 3'd7, 3, 1, -12'sd16));
        put_out(3);
        emit(enc_i(7'b0010011, 3'd1, 3, 1, 12'd7));
        put_out(3);
        emit(enc_i(7'b0010011, 3'd5, 3, 1, 12'd9));
        put_out(3);
        emit(enc_i(7'b0010011, 3'd5, 3, 1, {7'b0100000, 5'd9}));
        put_out(3);
        emit(enc_u(7'b0110111, 3, 20'hfffff));
        put_out(3);
        emit(enc_u(7'b0010111, 3, 20'h12345));
        put_out(3);
        addi(0, 1, 12'd5);
        put_out(0);
        put_halt();
        run_test("immediate ops");

        // sum of 1..10 followed by branch direction markers
        clear_prog();
        addi(1, 0, 12'd0);
        addi(2, 0, 12'd10);
        addi(3, 0, 12'd1);
        loop_at = wp;
        emit(enc_r(10'h000, 1, 1, 3));
        addi(3, 3, 12'd1);
        emit(enc_b(3'd5, 2, 3, 13'((loop_at - wp) * 4)));
        put_out(1);
        addi(4, 0, -12'sd5);
        addi(5, 0, 12'd3);
        for (int j = 0; j < 6; j++) begin
            for (int s = 0; s < 2; s++) begin
                addi(6, 0, 12'd1);
                emit(enc_b(br_fn[j], (s == 0) ? 4 : 5, (s == 0) ? 5 : 4, 13'd8));
                addi(6, 0, 12'd2);
                put_out(6);
            end
        end
        put_halt();
        run_test("branches");

        // stores to an array at byte 1024 and a checksum of the loads back
        clear_prog();
        addi(10, 0, 12'd1024);
        for (int i = 0; i < 8; i++) begin
            load_imm(1, $urandom);
            emit(enc_s(10, 1, 12'(4 * i)));
        end
        addi(2, 0, 12'd0);
        for (int i = 0; i < 8; i++) begin
            emit(enc_i(7'b0000011, 3'b010, 3, 10, 12'(4 * i)));
            emit(enc_r(10'h000, 2, 2, 3));
        end
        put_out(2);
        put_halt();
        run_test("loads and stores");

        // nothing after the halt store may run
        clear_prog();
        addi(1, 0, 12'd7);
        put_out(1);
        put_halt();
        addi(1, 0, 12'd9);
        put_out(1);
        put_halt();
        run_test("halt store");

        clear_prog();
        addi(1, 0, 12'd5);
        put_out(1);
        emit(32'h0000_007f);
        addi(1, 0, 12'd6);
        put_out(1);
        put_halt();
        run_test("unknown opcode");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/rv_core.sv ====
// multi-cycle RV32I subset core, no caches, stores to 1000 go out, a store to 1004 halts
module rv_core (
    input  logic             clk,
    input  logic             rst,
    output rv_pkg::mem_req_t mem_req,
    input  rv_pkg::data_t    mem_rd_data,
    input  logic             mem_ack,
    output rv_pkg::data_t    out_data,
    output logic             out_valid,
    output logic             halt
);
    import rv_pkg::*;

    instr_t   instr;
    addr_t    pc;
    decoded_t dec;
    data_t    rs1_data;
    data_t    rs2_data;
    data_t    alu_result;
    logic     branch_taken;
    logic     illegal;
    logic     wr_en;
    reg_sel_t wr_sel;
    data_t    wr_data;

    instr_decoder decoder0 (
        .instr (instr),
        .dec   (dec)
    );

    reg_file regs0 (
        .clk      (clk),
        .rst      (rst),
        .rs1_sel  (dec.rs1),
        .rs2_sel  (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_sel   (wr_sel),
        .wr_data  (wr_data)
    );

    alu alu0 (
        .dec          (dec),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .illegal      (illegal)
    );

    core_ctrl ctrl0 (
        .clk          (clk),
        .rst          (rst),
        .mem_ack      (mem_ack),
        .mem_rd_data  (mem_rd_data),
        .dec          (dec),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .illegal      (illegal),
        .instr        (instr),
        .pc           (pc),
        .mem_req      (mem_req),
        .wr_en        (wr_en),
        .wr_sel       (wr_sel),
        .wr_data      (wr_data),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .halt         (halt)
    );

endmodule

// ==== rtl/core_ctrl.sv ====
// one instruction at a time; waits on mem_ack forever, a lost acknowledge hangs the core
module core_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               mem_ack,
    input  rv_pkg::data_t      mem_rd_data,
    input  rv_pkg::decoded_t   dec,
    input  rv_pkg::data_t      rs1_data,
    input  rv_pkg::data_t      rs2_data,
    input  rv_pkg::data_t      alu_result,
    input  logic               branch_taken,
    input  logic               illegal,
    output rv_pkg::instr_t     instr,
    output rv_pkg::addr_t      pc,
    output rv_pkg::mem_req_t   mem_req,
    output logic               wr_en,
    output rv_pkg::reg_sel_t   wr_sel,
    output rv_pkg::data_t      wr_data,
    output rv_pkg::data_t      out_data,
    output logic               out_valid,
    output logic               halt
);
    import rv_pkg::*;

    core_state_e state;
    core_state_e state_next;
    instr_t      instr_q;
    addr_t       pc_next;
    addr_t       pc_plus;
    addr_t       branch_target;
    addr_t       ls_addr;
    logic        fetch_next;
    logic        stop;

    // decode straight from the bus in the acknowledge cycle, later from the latch
    assign instr = (state == WAIT_INSTR) ? mem_rd_data : instr_q;

    assign pc_plus = pc + instr_bytes;
    assign branch_target = pc + dec.b_imm;
    assign ls_addr = rs1_data + ((dec.opcode == LOAD) ? dec.i_imm : dec.s_imm);
    assign halt = (state == HALTED);

    always_comb begin
        state_next = state;
        pc_next = pc;
        fetch_next = 1'b0;
        stop = 1'b0;
        mem_req = '0;
        wr_en = 1'b0;
        wr_sel = dec.rd;
        wr_data = alu_result;
        out_data = '0;
        out_valid = 1'b0;
        case (state)
            FETCH: fetch_next = 1'b1;
            WAIT_INSTR: begin
                if (mem_ack) begin
                    pc_next = pc_plus;
                    fetch_next = 1'b1;
                    case (dec.opcode)
                        OPIMM, OP, LUI, AUIPC: wr_en = 1'b1;
                        BRANCH: begin
                            if (branch_taken) begin
                                pc_next = branch_target;
                            end
                        end
                        LOAD: begin
                            fetch_next = 1'b0;
                            pc_next = pc;
                            stop = (dec.funct3 != funct3_word);
                            mem_req.rd_req = 1'b1;
                            mem_req.addr = ls_addr;
                            state_next = WAIT_MEM;
                        end
                        STORE: begin
                            stop = (dec.funct3 != funct3_word);
                            if (ls_addr == out_addr) begin
                                out_valid = 1'b1;
                                out_data = rs2_data;
                            end else if (ls_addr == halt_addr) begin
                                stop = 1'b1;
                            end else begin
                                // real memory write, next fetch after the ack
                                fetch_next = 1'b0;
                                pc_next = pc;
                                mem_req.wr_req = 1'b1;
                                mem_req.addr = ls_addr;
                                mem_req.wr_data = rs2_data;
                                state_next = WAIT_MEM;
                            end
                        end
                        default: stop = 1'b1;
                    endcase
                    if (illegal) begin
                        stop = 1'b1;
                    end
                end
            end
            WAIT_MEM: begin
                if (mem_ack) begin
                    if (dec.opcode == LOAD) begin
                        wr_en = 1'b1;
                        wr_data = mem_rd_data;
                    end
                    pc_next = pc_plus;
                    fetch_next = 1'b1;
                end
            end
            default: state_next = HALTED;
        endcase

        // halting drops everything this instruction would have done
        if (stop) begin
            wr_en = 1'b0;
            out_valid = 1'b0;
            out_data = '0;
            mem_req = '0;
            pc_next = pc;
            state_next = HALTED;
        end else if (fetch_next) begin
            mem_req.rd_req = 1'b1;
            mem_req.addr = pc_next;
            state_next = WAIT_INSTR;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= FETCH;
            pc <= '0;
        end else begin
            state <= state_next;
            pc <= pc_next;
        end
    end

    // held for the data phase of LW and SW
    always_ff @(posedge clk) begin
        if ((state == WAIT_INSTR) && mem_ack) begin
            instr_q <= mem_rd_data;
        end
    end

endmodule

// ==== rtl/alu.sv ====
// combinational; only flags bad funct codes, unknown opcodes are caught by the control unit
module alu (
    input  rv_pkg::decoded_t dec,
    input  rv_pkg::addr_t    pc,
    input  rv_pkg::data_t    rs1_data,
    input  rv_pkg::data_t    rs2_data,
    output rv_pkg::data_t    alu_result,
    output logic             branch_taken,
    output logic             illegal
);
    import rv_pkg::*;

    logic [6:0] funct7;
    logic       arith;

    assign funct7 = dec.op_funct[9:3];
    // funct7 of SRAI
    assign arith = (funct7 == 7'b0100000);

    always_comb begin
        alu_result = '0;
        branch_taken = 1'b0;
        illegal = 1'b0;
        case (dec.opcode)
            OPIMM: begin
                case (dec.funct3)
                    ADDI: alu_result = rs1_data + dec.i_imm;
                    SLTI: alu_result = {{(data_width - 1){1'b0}},
                                        $signed(rs1_data) < $signed(dec.i_imm)};
                    SLTIU: alu_result = {{(data_width - 1){1'b0}}, rs1_data < dec.i_imm};
                    XORI: alu_result = rs1_data ^ dec.i_imm;
                    ORI: alu_result = rs1_data | dec.i_imm;
                    ANDI: alu_result = rs1_data & dec.i_imm;
                    SLLI: begin
                        // shamt sits in the rs2 field
                        alu_result = rs1_data << dec.rs2;
                        illegal = (funct7 != 7'b0);
                    end
                    SRLI: begin
                        if (arith) begin
                            alu_result = $signed(rs1_data) >>> dec.rs2;
                        end else begin
                            alu_result = rs1_data >> dec.rs2;
                        end
                        illegal = (funct7 != 7'b0) && !arith;
                    end
                    default: illegal = 1'b1;
                endcase
            end
            OP: begin
                case (dec.op_funct)
                    ADD: alu_result = rs1_data + rs2_data;
                    SUB: alu_result = rs1_data - rs2_data;
                    SLL: alu_result = rs1_data << rs2_data[4:0];
                    SLT: alu_result = {{(data_width - 1){1'b0}},
                                       $signed(rs1_data) < $signed(rs2_data)};
                    SLTU: alu_result = {{(data_width - 1){1'b0}}, rs1_data < rs2_data};
                    XOR: alu_result = rs1_data ^ rs2_data;
                    SRL: alu_result = rs1_data >> rs2_data[4:0];
                    SRA: alu_result = $signed(rs1_data) >>> rs2_data[4:0];
                    OR: alu_result = rs1_data | rs2_data;
                    AND: alu_result = rs1_data & rs2_data;
                    default: illegal = 1'b1;
                endcase
            end
            LUI: alu_result = dec.u_imm;
            AUIPC: alu_result = pc + dec.u_imm;
            BRANCH: begin
                case (dec.funct3)
                    BEQ: branch_taken = (rs1_data == rs2_data);
                    BNE: branch_taken = (rs1_data != rs2_data);
                    BLT: branch_taken = ($signed(rs1_data) < $signed(rs2_data));
                    BGE: branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
                    BLTU: branch_taken = (rs1_data < rs2_data);
                    BGEU: branch_taken = (rs1_data >= rs2_data);
                    default: illegal = 1'b1;
                endcase
            end
            default: alu_result = '0;
        endcase
    end

endmodule

// ==== rtl/reg_file.sv ====
// 32 x 32 registers, reads are combinational, write lands on the next rising edge
module reg_file (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::reg_sel_t rs1_sel,
    input  rv_pkg::reg_sel_t rs2_sel,
    output rv_pkg::data_t    rs1_data,
    output rv_pkg::data_t    rs2_data,
    input  logic             wr_en,
    input  rv_pkg::reg_sel_t wr_sel,
    input  rv_pkg::data_t    wr_data
);
    import rv_pkg::*;

    data_t regs [num_regs];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_sel != '0)) begin
            // x0 is never written
            regs[wr_sel] <= wr_data;
        end
    end

    // x0 reads zero
    assign rs1_data = (rs1_sel == '0) ? '0 : regs[rs1_sel];
    assign rs2_data = (rs2_sel == '0) ? '0 : regs[rs2_sel];

endmodule

// ==== rtl/instr_decoder.sv ====
// purely combinational field split; opcode and funct values are passed on unchecked
module instr_decoder (
    input  rv_pkg::instr_t   instr,
    output rv_pkg::decoded_t dec
);
    import rv_pkg::*;

    logic        sign;
    logic [6:0]  funct7;
    logic [2:0]  funct3;
    logic [11:0] i_field;
    logic [11:0] s_field;
    logic [12:0] b_field;
    logic [19:0] u_field;

    assign sign = instr[31];
    assign funct7 = instr[31:25];
    assign funct3 = instr[14:12];

    // I type, loads and register-immediate ops
    assign i_field = instr[31:20];

    // S type, split around rd
    assign s_field = {instr[31:25], instr[11:7]};

    // B type, bit 0 is always zero
    assign b_field = {
        instr[31],
        instr[7],
        instr[30:25],
        instr[11:8],
        1'b0
    };

    // U type, upper 20 bits
    assign u_field = instr[31:12];

    always_comb begin
        dec.opcode = opcode_e'(instr[6:0]);
        dec.rd = instr[11:7];
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.funct3 = funct3;
        dec.op_funct = op_funct_e'({funct7, funct3});

        dec.i_imm = {{(data_width - 12){sign}}, i_field};
        dec.s_imm = {{(data_width - 12){sign}}, s_field};
        dec.b_imm = {{(data_width - 13){sign}}, b_field};
        dec.u_imm = {u_field, 12'b0};
    end

endmodule

// ==== rtl/rv_pkg.sv ====
// RV32I subset encodings and types; word accesses only, byte addresses, fixed 1000/1004 map
package rv_pkg;

    localparam int data_width = 32;
    localparam int addr_width = 32;
    localparam int reg_sel_width = 5;
    localparam int num_regs = 32;

    typedef logic [data_width-1:0] data_t;
    typedef logic [addr_width-1:0] addr_t;
    typedef logic [data_width-1:0] instr_t;
    typedef logic [reg_sel_width-1:0] reg_sel_t;

    // memory-mapped words, not backed by memory
    localparam addr_t out_addr = 32'd1000;
    localparam addr_t halt_addr = 32'd1004;
    localparam addr_t instr_bytes = 32'd4;

    // LW and SW are the only load/store widths
    localparam logic [2:0] funct3_word = 3'b010;

    typedef enum logic [6:0] {
        OPIMM  = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    // SRLI and SRAI share a code, funct7 tells them apart
    typedef enum logic [2:0] {
        ADDI  = 3'b000,
        SLLI  = 3'b001,
        SLTI  = 3'b010,
        SLTIU = 3'b011,
        XORI  = 3'b100,
        SRLI  = 3'b101,
        ORI   = 3'b110,
        ANDI  = 3'b111
    } funct3_imm_e;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } funct3_branch_e;

    // {funct7, funct3}
    typedef enum logic [9:0] {
        ADD  = 10'b0000000_000,
        SUB  = 10'b0100000_000,
        SLL  = 10'b0000000_001,
        SLT  = 10'b0000000_010,
        SLTU = 10'b0000000_011,
        XOR  = 10'b0000000_100,
        SRL  = 10'b0000000_101,
        SRA  = 10'b0100000_101,
        OR   = 10'b0000000_110,
        AND  = 10'b0000000_111
    } op_funct_e;

    typedef enum logic [1:0] {
        FETCH,
        WAIT_INSTR,
        WAIT_MEM,
        HALTED
    } core_state_e;

    // immediates are sign-extended and already shifted into place
    typedef struct packed {
        opcode_e   opcode;
        reg_sel_t  rd;
        reg_sel_t  rs1;
        reg_sel_t  rs2;
        logic [2:0] funct3;
        op_funct_e op_funct;
        data_t     i_imm;
        data_t     s_imm;
        data_t     b_imm;
        data_t     u_imm;
    } decoded_t;

    typedef struct packed {
        addr_t addr;
        data_t wr_data;
        logic  rd_req;
        logic  wr_req;
    } mem_req_t;

endpackage
